// File: hdl/smc_host_pkg.sv
package smc_host_pkg;

  // --------------------------------------------------
  // host address space
  // --------------------------------------------------

  // byte address, 4 KiB device
  localparam int ADDR_W = 12;

  // --------------------------------------------------
  // external cycle timing, in sys_clk cycles
  // --------------------------------------------------

  localparam int SETUP_CYCLES  = 1;
  localparam int STROBE_CYCLES = 2;
  localparam int HOLD_CYCLES   = 1;

  // whole transfer, n_cs low and busy high
  localparam int CYCLE_LEN = SETUP_CYCLES + STROBE_CYCLES + HOLD_CYCLES;

  // phase down-counter, wide enough for the longest phase
  localparam int PHASE_CNT_W = 2;

  // transfer size
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } smc_size_t;

  // one host transfer
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    smc_size_t         size;
    logic [31:0]       wdata;
  } smc_req_t;

  // read result, zero-extended
  typedef struct packed {
    logic [31:0] rdata;
    logic        ok;
  } smc_rsp_t;

endpackage

// File: hdl/smc_bus_pkg.sv
package smc_bus_pkg;

  // --------------------------------------------------
  // external device bus
  // --------------------------------------------------

  localparam int LANES  = 4;
  localparam int DATA_W = 32;

  // word address, byte address minus the lane bits
  localparam int MEM_ADDR_W = smc_host_pkg::ADDR_W - 2;

  // sequencer phases, shared by decode and checker
  typedef enum logic [1:0] {
    PH_IDLE   = 2'd0,
    PH_SETUP  = 2'd1,
    PH_STROBE = 2'd2,
    PH_HOLD   = 2'd3
  } smc_phase_t;

  // everything driven towards the device
  // all strobes active low
  typedef struct packed {
    logic [MEM_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     wdata;
    logic                  drive;
    logic                  n_cs;
    logic                  n_oe;
    logic [LANES-1:0]      n_we;
    logic                  n_wr;
  } smc_bus_out_t;

endpackage

// File: hdl/smc_state_lite.sv
module smc_state_lite
  import smc_host_pkg::*, smc_bus_pkg::*;
(
  input  logic       sys_clk,
  input  logic       reset,
  input  logic       req_valid,
  input  smc_req_t   req,
  output smc_phase_t phase,
  output smc_req_t   cur_req,
  output logic       r_full,
  output logic       sample,
  output logic       busy,
  output logic       done
);

  // cycles left in the current phase, counts down to zero
  logic [PHASE_CNT_W-1:0] phase_cnt;
  logic                   accept;
  logic                   phase_last;

  // only taken while idle, strobes during a transfer are dropped
  assign accept     = req_valid && (phase == PH_IDLE);
  assign phase_last = (phase_cnt == '0);

  // --------------------------------------------------
  // phase walk
  // --------------------------------------------------

  always_ff @(posedge sys_clk)
  begin
    if (reset)
    begin
      phase     <= PH_IDLE;
      phase_cnt <= '0;
    end
    else
    begin
      case (phase)
        PH_IDLE:
        begin
          if (accept)
          begin
            phase     <= PH_SETUP;
            phase_cnt <= PHASE_CNT_W'(SETUP_CYCLES - 1);
          end
        end
        PH_SETUP:
        begin
          if (phase_last)
          begin
            phase     <= PH_STROBE;
            phase_cnt <= PHASE_CNT_W'(STROBE_CYCLES - 1);
          end
          else
            phase_cnt <= phase_cnt - 1'b1;
        end
        PH_STROBE:
        begin
          if (phase_last)
          begin
            phase     <= PH_HOLD;
            phase_cnt <= PHASE_CNT_W'(HOLD_CYCLES - 1);
          end
          else
            phase_cnt <= phase_cnt - 1'b1;
        end
        default:
        begin
          // hold, back to idle after the last cycle
          if (phase_last)
            phase <= PH_IDLE;
          else
            phase_cnt <= phase_cnt - 1'b1;
        end
      endcase
    end
  end

  // request payload, kept for the whole transfer
  always_ff @(posedge sys_clk)
  begin
    if (accept)
      cur_req <= req;
  end

  // --------------------------------------------------
  // status and timing strobes
  // --------------------------------------------------

  assign busy = (phase != PH_IDLE);
  assign done = (phase == PH_HOLD) && phase_last;

  // last strobe cycle of a read, data is stable on the bus here
  assign sample = (phase == PH_STROBE) && phase_last && !cur_req.write;

  // write window one cycle early
  // the gating register moves it into the strobe phase
  assign r_full = cur_req.write &&
                  (((phase == PH_SETUP) && phase_last) ||
                   ((phase == PH_STROBE) && !phase_last));

endmodule

// File: hdl/smc_strobe_lite.sv
module smc_strobe_lite
  import smc_host_pkg::*, smc_bus_pkg::*;
(
  input  smc_phase_t        phase,
  input  smc_req_t          cur_req,
  output logic [LANES-1:0]  lane_mask,
  output logic [LANES-1:0]  n_r_we,
  output logic              n_r_wr,
  output logic              n_oe,
  output logic              n_cs,
  output logic [DATA_W-1:0] wdata_lanes
);

  logic       active;
  logic       wr_active;
  logic       rd_active;
  logic [1:0] lane_sel;

  assign lane_sel = cur_req.addr[1:0];

  // --------------------------------------------------
  // lane selection
  // --------------------------------------------------

  // little-endian lanes, lane 0 is bits 7:0
  always_comb
  begin
    case (cur_req.size)
      SZ_BYTE:
        lane_mask = LANES'(1) << lane_sel;
      SZ_HALF:
        // halfwords sit on even addresses, bit 1 picks the pair
        lane_mask = lane_sel[1] ? 4'b1100 : 4'b0011;
      default:
        lane_mask = '1;
    endcase
  end

  // write data copied onto every lane it may land on
  always_comb
  begin
    case (cur_req.size)
      SZ_BYTE:
        wdata_lanes = {4{cur_req.wdata[7:0]}};
      SZ_HALF:
        wdata_lanes = {2{cur_req.wdata[15:0]}};
      default:
        wdata_lanes = cur_req.wdata;
    endcase
  end

  // --------------------------------------------------
  // raw strobes, active low
  // --------------------------------------------------

  assign active    = (phase != PH_IDLE);
  assign wr_active = active && cur_req.write;

  // setup and strobe only, released for hold
  assign rd_active = !cur_req.write && ((phase == PH_SETUP) || (phase == PH_STROBE));

  // chip select spans the whole transfer
  assign n_cs = !active;
  assign n_oe = !rd_active;

  // raw write strobes cover every busy write phase
  // narrowed to the strobe window later
  assign n_r_we = wr_active ? ~lane_mask : '1;
  assign n_r_wr = !wr_active;

endmodule

// File: hdl/smc_wr_enable_lite.sv
module smc_wr_enable_lite
  import smc_host_pkg::*, smc_bus_pkg::*;
(
  input  logic             sys_clk,
  input  logic             reset,
  input  logic             r_full,
  input  logic [LANES-1:0] n_r_we,
  input  logic             n_r_wr,
  input  logic             wr_cycle,
  output logic [LANES-1:0] smc_n_we,
  output logic             smc_n_wr,
  output logic             smc_drive
);

  // cycles of drive left after the current one
  logic [$clog2(CYCLE_LEN)-1:0] drive_cnt;

  // --------------------------------------------------
  // gated write strobes
  // --------------------------------------------------

  // lanes held high outside the full-cycle window
  // registered so decode hazards never reach the pins
  always_ff @(posedge sys_clk)
  begin
    if (reset)
    begin
      smc_n_we <= '1;
      smc_n_wr <= 1'b1;
    end
    else
    begin
      smc_n_we <= n_r_we | {LANES{~r_full}};
      smc_n_wr <= n_r_wr | ~r_full;
    end
  end

  // --------------------------------------------------
  // data bus drive
  // --------------------------------------------------

  // wr_cycle marks a write being taken, drive then runs the full cycle
  always_ff @(posedge sys_clk)
  begin
    if (reset)
    begin
      smc_drive <= 1'b0;
      drive_cnt <= '0;
    end
    else if (wr_cycle)
    begin
      smc_drive <= 1'b1;
      drive_cnt <= $bits(drive_cnt)'(CYCLE_LEN - 1);
    end
    else if (smc_drive)
    begin
      if (drive_cnt == '0)
        smc_drive <= 1'b0;
      else
        drive_cnt <= drive_cnt - 1'b1;
    end
  end

endmodule

// File: hdl/smc_rdata_lite.sv
module smc_rdata_lite
  import smc_host_pkg::*, smc_bus_pkg::*;
(
  input  logic              sys_clk,
  input  logic              reset,
  input  logic              sample,
  input  smc_req_t          cur_req,
  input  logic [DATA_W-1:0] mem_rdata,
  output smc_rsp_t          rsp
);

  logic [DATA_W-1:0] shifted;
  logic [DATA_W-1:0] aligned;

  // --------------------------------------------------
  // lane alignment
  // --------------------------------------------------

  // addressed lane moved down to bit 0
  assign shifted = mem_rdata >> {cur_req.addr[1:0], 3'b000};

  // zero-extend by size
  always_comb
  begin
    case (cur_req.size)
      SZ_BYTE:
        aligned = {24'd0, shifted[7:0]};
      SZ_HALF:
        aligned = {16'd0, shifted[15:0]};
      default:
        aligned = mem_rdata;
    endcase
  end

  // data word, held until the next read
  always_ff @(posedge sys_clk)
  begin
    if (sample)
      rsp.rdata <= aligned;
  end

  // done marker, set by the first read
  always_ff @(posedge sys_clk)
  begin
    if (reset)
      rsp.ok <= 1'b0;
    else if (sample)
      rsp.ok <= 1'b1;
  end

endmodule

// File: hdl/smc_lite.sv
module smc_lite
  import smc_host_pkg::*, smc_bus_pkg::*;
(
  input  logic              sys_clk,
  input  logic              reset,
  input  logic              req_valid,
  input  smc_req_t          req,
  output logic              busy,
  output logic              done,
  output smc_rsp_t          rsp,
  output smc_bus_out_t      bus,
  input  logic [DATA_W-1:0] mem_rdata
);

  smc_phase_t        phase;
  smc_req_t          cur_req;
  logic              r_full;
  logic              sample;
  logic              wr_start;
  logic [LANES-1:0]  lane_mask;
  logic [LANES-1:0]  n_r_we;
  logic              n_r_wr;
  logic [DATA_W-1:0] wdata_lanes;

  // write taken this cycle, starts the drive window
  assign wr_start = req_valid && !busy && req.write;

  // --------------------------------------------------
  // sequencer and decode
  // --------------------------------------------------

  smc_state_lite i_state (
    .sys_clk   (sys_clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .phase     (phase),
    .cur_req   (cur_req),
    .r_full    (r_full),
    .sample    (sample),
    .busy      (busy),
    .done      (done)
  );

  smc_strobe_lite i_strobe (
    .phase       (phase),
    .cur_req     (cur_req),
    .lane_mask   (lane_mask),
    .n_r_we      (n_r_we),
    .n_r_wr      (n_r_wr),
    .n_oe        (bus.n_oe),
    .n_cs        (bus.n_cs),
    .wdata_lanes (wdata_lanes)
  );

  // --------------------------------------------------
  // pin stages
  // --------------------------------------------------

  smc_wr_enable_lite i_wr_enable (
    .sys_clk   (sys_clk),
    .reset     (reset),
    .r_full    (r_full),
    .n_r_we    (n_r_we),
    .n_r_wr    (n_r_wr),
    .wr_cycle  (wr_start),
    .smc_n_we  (bus.n_we),
    .smc_n_wr  (bus.n_wr),
    .smc_drive (bus.drive)
  );

  smc_rdata_lite i_rdata (
    .sys_clk   (sys_clk),
    .reset     (reset),
    .sample    (sample),
    .cur_req   (cur_req),
    .mem_rdata (mem_rdata),
    .rsp       (rsp)
  );

  // word address and lane data straight from the held request
  assign bus.addr  = cur_req.addr[ADDR_W-1:2];
  assign bus.wdata = wdata_lanes;

endmodule

// File: bench/smc_lite_chk.sv
module smc_lite_chk
  import smc_host_pkg::*, smc_bus_pkg::*;
(
  input logic             sys_clk,
  input logic             reset,
  input logic             busy,
  input logic             done,
  input smc_bus_out_t     bus,
  input logic [LANES-1:0] lane_mask
);

  timeunit 1ns;
  timeprecision 1ps;

  // count of failed assertions
  int fail_count = 0;

  // --------------------------------------------------
  // strobe exclusivity
  // --------------------------------------------------

  a_we_oe: assert property (@(posedge sys_clk) disable iff (reset)
    !((bus.n_we != '1) && !bus.n_oe))
    else begin $error("n_we and n_oe low together"); fail_count++; end

  a_we_cs: assert property (@(posedge sys_clk) disable iff (reset)
    (bus.n_we != '1) |-> !bus.n_cs)
    else begin $error("n_we low while n_cs high"); fail_count++; end

  // lane enables and write strobe move together
  a_we_wr: assert property (@(posedge sys_clk) disable iff (reset)
    bus.n_wr == (bus.n_we == '1))
    else begin $error("n_wr and n_we out of step"); fail_count++; end

  // --------------------------------------------------
  // strobe shape
  // --------------------------------------------------

  // only the decoded lanes go low
  a_lanes: assert property (@(posedge sys_clk) disable iff (reset)
    !bus.n_wr |-> (bus.n_we == ~lane_mask))
    else begin $error("n_we lanes differ from lane mask"); fail_count++; end

  a_width: assert property (@(posedge sys_clk) disable iff (reset)
    $fell(bus.n_wr) |-> (!bus.n_wr) [*STROBE_CYCLES] ##1 bus.n_wr)
    else begin $error("n_wr low for wrong number of cycles"); fail_count++; end

  a_done: assert property (@(posedge sys_clk) disable iff (reset)
    done |=> !busy)
    else begin $error("busy not released after done"); fail_count++; end

endmodule

bind smc_lite smc_lite_chk i_chk (
  .sys_clk   (sys_clk),
  .reset     (reset),
  .busy      (busy),
  .done      (done),
  .bus       (bus),
  .lane_mask (lane_mask)
);

// File: bench/smc_lite_monitor.sv
module smc_lite_monitor
  import smc_host_pkg::*, smc_bus_pkg::*;
(
  input logic         sys_clk,
  input logic         reset,
  input logic         req_valid,
  input smc_req_t     req,
  input logic         busy,
  input logic         done,
  input smc_rsp_t     rsp,
  input smc_bus_out_t bus
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [DATA_W-1:0] model [1 << MEM_ADDR_W];
  smc_req_t          cur;
  logic              pending = 1'b0;
  logic              in_strobe;
  logic              rd_window;
  logic [DATA_W-1:0] bits;
  logic [DATA_W-1:0] placed;
  logic [DATA_W-1:0] expect_rd;
  logic [LANES-1:0]  lanes;
  int                cyc;
  int                shift;
  int                test_errors = 0;
  int                test_xfers = 0;
  int                error_total = 0;
  int                xfer_total = 0;

  // same fill as the testbench SRAM
  initial
  begin
    for (int i = 0; i < (1 << MEM_ADDR_W); i++)
      model[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  end

  task automatic log_error(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    test_errors++;
    error_total++;
  endtask

  task automatic report_test(input string name);
    $display("test %s: %0d transfers, %0d errors", name, test_xfers, test_errors);
    test_xfers  = 0;
    test_errors = 0;
  endtask

  // --------------------------------------------------
  // per-edge bus and host checks
  // --------------------------------------------------

  always @(posedge sys_clk)
  begin
    if (reset)
      pending = 1'b0;
    else if (!pending)
    begin
      // between transfers everything parked
      if (busy || done || !bus.n_cs || !bus.n_oe || bus.n_we != '1 || !bus.n_wr || bus.drive)
        log_error("bus or host status not idle between transfers");
    end
    else
    begin
      cyc++;
      in_strobe = cur.write && (cyc > SETUP_CYCLES) && (cyc <= SETUP_CYCLES + STROBE_CYCLES);
      rd_window = !cur.write && (cyc <= SETUP_CYCLES + STROBE_CYCLES);
      if (!busy || bus.n_cs || bus.drive != cur.write)
        log_error($sformatf("busy %b n_cs %b drive %b in cycle %0d", busy, bus.n_cs,
                            bus.drive, cyc));
      if (bus.n_we != (in_strobe ? ~lanes : 4'hf) || bus.n_wr != !in_strobe)
        log_error($sformatf("n_we %b n_wr %b in cycle %0d", bus.n_we, bus.n_wr, cyc));
      if (bus.n_oe == rd_window)
        log_error($sformatf("n_oe %b in cycle %0d", bus.n_oe, cyc));
      if (bus.addr != cur.addr[ADDR_W-1:2])
        log_error($sformatf("bus address %h, expected %h", bus.addr, cur.addr[ADDR_W-1:2]));
      if (in_strobe && (bus.wdata & bits) != placed)
        log_error($sformatf("bus write data %h, expected %h", bus.wdata & bits, placed));
      if (done)
      begin
        if (cyc != CYCLE_LEN)
          log_error($sformatf("done after %0d cycles, expected %0d", cyc, CYCLE_LEN));
        if (!cur.write && rsp.rdata !== expect_rd)
          log_error($sformatf("read %h at %h, expected %h", rsp.rdata, cur.addr, expect_rd));
        if (!cur.write && rsp.ok !== 1'b1)
          log_error($sformatf("read at %h done without response marker", cur.addr));
        test_xfers++;
        xfer_total++;
        pending = 1'b0;
      end
      else if (cyc >= CYCLE_LEN + 3)
      begin
        $display("no completion seen for transfer to address %h", cur.addr);
        test_errors++;
        error_total++;
        pending = 1'b0;
      end
    end

    // model updated in request order on acceptance
    if (!reset && req_valid && !busy)
    begin
      cur     = req;
      pending = 1'b1;
      cyc     = 0;
      if (req.size == SZ_WORD)
        shift = 0;
      else if (req.size == SZ_HALF)
        shift = req.addr[1] ? 2 : 0;
      else
        shift = req.addr[1:0];
      bits = (req.size == SZ_WORD) ? 32'hffff_ffff : (req.size == SZ_HALF) ? 32'hffff : 32'hff;
      bits   = bits << (8 * shift);
      placed = (req.wdata << (8 * shift)) & bits;
      lanes  = {bits[24], bits[16], bits[8], bits[0]};
      if (req.write)
        model[req.addr[ADDR_W-1:2]] = (model[req.addr[ADDR_W-1:2]] & ~bits) | placed;
      else
        expect_rd = (model[req.addr[ADDR_W-1:2]] & bits) >> (8 * shift);
    end
  end

endmodule

// File: bench/tb_smc_lite.sv
module tb_smc_lite
  import smc_host_pkg::*, smc_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_WORD    = 200;
  localparam int N_SUBWORD = 300;
  localparam int N_B2B     = 100;
  localparam int N_XFERS   = 2 * N_WORD + N_SUBWORD + N_B2B;
  // accept cycle plus up to two idle cycles per transfer
  localparam int TIMEOUT_CYCLES = N_XFERS * (CYCLE_LEN + 3) + 50;

  logic              sys_clk = 1'b0;
  logic              reset;
  logic              req_valid;
  smc_req_t          req;
  logic              busy;
  logic              done;
  smc_rsp_t          rsp;
  smc_bus_out_t      bus;
  logic [DATA_W-1:0] mem_rdata;
  logic [DATA_W-1:0] sram [1 << MEM_ADDR_W];
  logic [ADDR_W-1:0] word_addr [N_WORD];
  int                cycle_cnt = 0;

  always #20 sys_clk = ~sys_clk;

  // run limit
  always @(posedge sys_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
      $display("Done: errors found");
      $finish;
    end
  end

  // --------------------------------------------------
  // behavioral SRAM
  // --------------------------------------------------

  initial
  begin
    for (int i = 0; i < (1 << MEM_ADDR_W); i++)
      sram[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  end

  // lane written on the trailing edge of its enable
  for (genvar l = 0; l < LANES; l++)
  begin : g_lane
    always @(posedge bus.n_we[l])
    begin
      if (!reset && !bus.n_cs)
        sram[bus.addr][8*l +: 8] <= bus.wdata[8*l +: 8];
    end
  end

  assign mem_rdata = (!bus.n_oe && !bus.n_cs) ? sram[bus.addr] : {DATA_W{1'bx}};

  smc_lite i_smc_lite (
    .sys_clk   (sys_clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .busy      (busy),
    .done      (done),
    .rsp       (rsp),
    .bus       (bus),
    .mem_rdata (mem_rdata)
  );

  smc_lite_monitor i_mon (
    .sys_clk   (sys_clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .busy      (busy),
    .done      (done),
    .rsp       (rsp),
    .bus       (bus)
  );

  // --------------------------------------------------
  // host stimulus
  // --------------------------------------------------

  // called on a rising edge, returns on the edge closing the last hold cycle
  task automatic issue(input logic write, input smc_size_t size, input logic [ADDR_W-1:0] addr,
                       input int gap);
    smc_req_t r;
    r.addr  = addr;
    r.write = write;
    r.size  = size;
    r.wdata = $urandom;
    repeat (gap) @(posedge sys_clk);
    req       <= r;
    req_valid <= 1'b1;
    @(posedge sys_clk);
    req_valid <= 1'b0;
    while (!done)
      @(posedge sys_clk);
  endtask

  // random size, address aligned to it, inside a byte window
  task automatic random_xfer(input bit sub_writes, input int window, input int max_gap);
    logic              write;
    smc_size_t         size;
    logic [ADDR_W-1:0] addr;
    write = $urandom % 2;
    size  = smc_size_t'((write && sub_writes) ? $urandom % 2 : $urandom % 3);
    addr  = ADDR_W'($urandom % window);
    if (size == SZ_HALF)
      addr[0] = 1'b0;
    else if (size == SZ_WORD)
      addr[1:0] = 2'b00;
    issue(write, size, addr, $urandom % (max_gap + 1));
  endtask

  task automatic end_test(input string name);
    repeat (2) @(posedge sys_clk);
    @(negedge sys_clk);
    i_mon.report_test(name);
    @(posedge sys_clk);
  endtask

  initial
  begin
    void'($urandom(32'he4a));
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    repeat (3) @(posedge sys_clk);
    reset <= 1'b0;
    repeat (2) @(posedge sys_clk);

    for (int i = 0; i < N_WORD; i++)
    begin
      word_addr[i] = ADDR_W'($urandom) & ~ADDR_W'(3);
      issue(1'b1, SZ_WORD, word_addr[i], $urandom % 3);
    end
    for (int i = 0; i < N_WORD; i++)
      issue(1'b0, SZ_WORD, word_addr[i], $urandom % 3);
    end_test("word_write_read");

    // small window so reads land on freshly written lanes
    for (int i = 0; i < N_SUBWORD; i++)
      random_xfer(1'b1, 64, 2);
    end_test("sub_word_lanes");

    for (int i = 0; i < N_B2B; i++)
      random_xfer(1'b0, 1 << ADDR_W, 0);
    end_test("back_to_back");

    $display("summary: %0d transfers of %0d, %0d check errors, %0d assertion failures",
             i_mon.xfer_total, N_XFERS, i_mon.error_total, i_smc_lite.i_chk.fail_count);
    if (i_mon.xfer_total != N_XFERS)
      $display("transfers were lost, fewer completions than requests");
    if (i_mon.error_total == 0 && i_smc_lite.i_chk.fail_count == 0 &&
        i_mon.xfer_total == N_XFERS)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// File: build.f
hdl/smc_host_pkg.sv
hdl/smc_bus_pkg.sv
hdl/smc_state_lite.sv
hdl/smc_strobe_lite.sv
hdl/smc_wr_enable_lite.sv
hdl/smc_rdata_lite.sv
hdl/smc_lite.sv
bench/smc_lite_chk.sv
bench/smc_lite_monitor.sv
bench/tb_smc_lite.sv

// File: Bender.yml
package:
  name: smc_lite

sources:
  - target: rtl
    files:
      - hdl/smc_host_pkg.sv
      - hdl/smc_bus_pkg.sv
      - hdl/smc_state_lite.sv
      - hdl/smc_strobe_lite.sv
      - hdl/smc_wr_enable_lite.sv
      - hdl/smc_rdata_lite.sv
      - hdl/smc_lite.sv

  - target: bench
    files:
      - bench/smc_lite_chk.sv
      - bench/smc_lite_monitor.sv
      - bench/tb_smc_lite.sv
